/* src/noc_pkg.sv */
package noc_pkg;

  // Flit layout
  localparam int FLIT_W    = 16;
  localparam int DEST_W    = 6;
  localparam int PAYLOAD_W = 10;
  localparam int SPINE_W   = 2;
  localparam int COUNT_W   = 16;

  // Port list is built for exactly four spines
  localparam int NUM_SPINES = 4;

  typedef logic [FLIT_W-1:0]    flit_t;
  typedef logic [DEST_W-1:0]    node_addr_t;  // Group in [5:2], spine index in [1:0]
  typedef logic [PAYLOAD_W-1:0] payload_t;
  typedef logic [COUNT_W-1:0]   count_t;      // Wraps around
  typedef logic [SPINE_W-1:0]   spine_idx_t;

  // Destination sits in the top bits of the flit
  function automatic node_addr_t flit_dest(input flit_t f);
    return f[FLIT_W-1 -: DEST_W];
  endfunction

  function automatic payload_t flit_payload(input flit_t f);
    return f[PAYLOAD_W-1:0];
  endfunction

  function automatic flit_t make_flit(input node_addr_t dest, input payload_t payload);
    return {dest, payload};
  endfunction

  // Spine chosen by the low destination bits
  function automatic spine_idx_t dest_spine(input node_addr_t dest);
    return dest[SPINE_W-1:0];
  endfunction

endpackage

/* src/spine_fifo.sv */
`timescale 1ns/10ps
module spine_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic           ACLK,
  input  logic           rst,
  input  logic           wr_en,
  input  noc_pkg::flit_t wr_flit,
  input  logic           rd_en,
  output noc_pkg::flit_t rd_flit,
  output logic           full,
  output logic           empty
);
  import noc_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  flit_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);
  assign do_wr = wr_en && !full;  // Write while full is lost here
  assign do_rd = rd_en && !empty;

  assign rd_flit = mem[rd_ptr];   // Head is visible without a read strobe

  always_ff @(posedge ACLK) begin
    if (do_wr) mem[wr_ptr] <= wr_flit;
  end

  always_ff @(posedge ACLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      case ({do_wr, do_rd})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

/* src/downlink_arbiter.sv */
`timescale 1ns/10ps
module downlink_arbiter #(
  parameter noc_pkg::node_addr_t NODE_ADDR  = 6'b010011,
  parameter int                  FIFO_DEPTH = 4
) (
  input  logic                                         ACLK,
  input  logic                                         rst,
  input  noc_pkg::flit_t      [noc_pkg::NUM_SPINES-1:0] spine_data,
  input  logic                [noc_pkg::NUM_SPINES-1:0] spine_valid,
  input  noc_pkg::node_addr_t [noc_pkg::NUM_SPINES-1:0] spine_dest,
  output noc_pkg::flit_t                               down_flit,
  output logic                                         down_valid,
  output noc_pkg::spine_idx_t                          down_spine,
  output logic [2:0]                                   drop_num
);
  import noc_pkg::*;

  logic  [NUM_SPINES-1:0] addr_hit;
  logic  [NUM_SPINES-1:0] wr_en;
  logic  [NUM_SPINES-1:0] drop_vec;
  logic  [NUM_SPINES-1:0] pop_en;
  logic  [NUM_SPINES-1:0] fifo_full;
  logic  [NUM_SPINES-1:0] fifo_empty;
  flit_t [NUM_SPINES-1:0] fifo_head;

  spine_idx_t rr_ptr;       // First spine to look at this cycle
  spine_idx_t cand;
  spine_idx_t grant_idx;
  logic       grant_found;

  for (genvar n = 0; n < NUM_SPINES; n++) begin : g_spine
    assign addr_hit[n] = (spine_dest[n] == NODE_ADDR);
    assign wr_en[n]    = spine_valid[n] && addr_hit[n] && !fifo_full[n];
    assign drop_vec[n] = spine_valid[n] && !wr_en[n];  // Wrong address or no room
    assign pop_en[n]   = grant_found && (grant_idx == spine_idx_t'(n));

    spine_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) i_spine_fifo (
      .ACLK    (ACLK),
      .rst     (rst),
      .wr_en   (wr_en[n]),
      .wr_flit (spine_data[n]),
      .rd_en   (pop_en[n]),
      .rd_flit (fifo_head[n]),
      .full    (fifo_full[n]),
      .empty   (fifo_empty[n])
    );
  end

  // Several spines can drop in the same cycle
  always_comb begin
    drop_num = '0;
    for (int n = 0; n < NUM_SPINES; n++) begin
      drop_num = drop_num + 3'(drop_vec[n]);
    end
  end

  // Round-robin search starting at rr_ptr
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = rr_ptr;
    cand        = rr_ptr;
    for (int i = 0; i < NUM_SPINES; i++) begin
      cand = rr_ptr + spine_idx_t'(i);  // Wraps at four
      if (!grant_found && !fifo_empty[cand]) begin
        grant_found = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (rst) begin
      down_valid <= 1'b0;
      rr_ptr     <= '0;
    end else begin
      down_valid <= grant_found;
      if (grant_found) rr_ptr <= grant_idx + spine_idx_t'(1);  // Next search after winner
    end
  end

  always_ff @(posedge ACLK) begin
    if (grant_found) begin
      down_flit  <= fifo_head[grant_idx];
      down_spine <= grant_idx;
    end
  end

endmodule

/* src/uplink_steer.sv */
`timescale 1ns/10ps
module uplink_steer (
  input  logic                                    ACLK,
  input  logic                                    rst,
  input  noc_pkg::flit_t                          up_flit,
  input  logic                                    up_valid,
  output noc_pkg::flit_t [noc_pkg::NUM_SPINES-1:0] spine_out_data,
  output logic           [noc_pkg::NUM_SPINES-1:0] spine_out_valid
);
  import noc_pkg::*;

  spine_idx_t            sel_idx;
  logic [NUM_SPINES-1:0] sel_onehot;

  assign sel_idx = dest_spine(flit_dest(up_flit));

  always_comb begin
    sel_onehot = '0;
    if (up_valid) sel_onehot[sel_idx] = 1'b1;
  end

  always_ff @(posedge ACLK) begin
    if (rst) begin
      spine_out_valid <= '0;
    end else begin
      spine_out_valid <= sel_onehot;  // Other spines stay quiet
    end
  end

  // Only the chosen spine loads the new flit
  for (genvar n = 0; n < NUM_SPINES; n++) begin : g_out
    always_ff @(posedge ACLK) begin
      if (sel_onehot[n]) spine_out_data[n] <= up_flit;
    end
  end

endmodule

/* src/leaf_router.sv */
`timescale 1ns/10ps
module leaf_router #(
  parameter noc_pkg::node_addr_t NODE_ADDR  = 6'b010011,
  parameter int                  FIFO_DEPTH = 4
) (
  input  logic                ACLK,
  input  logic                rst,
  input  noc_pkg::flit_t      spine0_in_data,
  input  logic                spine0_in_valid,
  input  noc_pkg::node_addr_t spine0_dest_addr,
  output noc_pkg::flit_t      spine0_out_data,
  output logic                spine0_out_valid,
  input  noc_pkg::flit_t      spine1_in_data,
  input  logic                spine1_in_valid,
  input  noc_pkg::node_addr_t spine1_dest_addr,
  output noc_pkg::flit_t      spine1_out_data,
  output logic                spine1_out_valid,
  input  noc_pkg::flit_t      spine2_in_data,
  input  logic                spine2_in_valid,
  input  noc_pkg::node_addr_t spine2_dest_addr,
  output noc_pkg::flit_t      spine2_out_data,
  output logic                spine2_out_valid,
  input  noc_pkg::flit_t      spine3_in_data,
  input  logic                spine3_in_valid,
  input  noc_pkg::node_addr_t spine3_dest_addr,
  output noc_pkg::flit_t      spine3_out_data,
  output logic                spine3_out_valid,
  input  noc_pkg::flit_t      up_flit,
  input  logic                up_valid,
  output noc_pkg::flit_t      down_flit,
  output logic                down_valid,
  output noc_pkg::spine_idx_t down_spine,
  output noc_pkg::count_t     drop_count
);
  import noc_pkg::*;

  flit_t      [NUM_SPINES-1:0] in_data;
  logic       [NUM_SPINES-1:0] in_valid;
  node_addr_t [NUM_SPINES-1:0] in_dest;
  flit_t      [NUM_SPINES-1:0] out_data;
  logic       [NUM_SPINES-1:0] out_valid;
  logic [2:0]                  drop_num;

  // Spine 0 lands in element 0
  assign in_data  = {spine3_in_data, spine2_in_data, spine1_in_data, spine0_in_data};
  assign in_valid = {spine3_in_valid, spine2_in_valid, spine1_in_valid, spine0_in_valid};
  assign in_dest  = {spine3_dest_addr, spine2_dest_addr, spine1_dest_addr, spine0_dest_addr};

  assign {spine3_out_data, spine2_out_data, spine1_out_data, spine0_out_data} = out_data;
  assign {spine3_out_valid, spine2_out_valid, spine1_out_valid, spine0_out_valid} = out_valid;

  uplink_steer i_uplink_steer (
    .ACLK            (ACLK),
    .rst             (rst),
    .up_flit         (up_flit),
    .up_valid        (up_valid),
    .spine_out_data  (out_data),
    .spine_out_valid (out_valid)
  );

  downlink_arbiter #(
    .NODE_ADDR  (NODE_ADDR),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_downlink_arbiter (
    .ACLK        (ACLK),
    .rst         (rst),
    .spine_data  (in_data),
    .spine_valid (in_valid),
    .spine_dest  (in_dest),
    .down_flit   (down_flit),
    .down_valid  (down_valid),
    .down_spine  (down_spine),
    .drop_num    (drop_num)
  );

  always_ff @(posedge ACLK) begin
    if (rst) begin
      drop_count <= '0;
    end else begin
      drop_count <= drop_count + count_t'(drop_num);  // Up to four per cycle
    end
  end

endmodule

/* src/node_ni.sv */
`timescale 1ns/10ps
module node_ni (
  input  logic                ACLK,
  input  logic                rst,
  input  logic                tx_valid,
  input  noc_pkg::node_addr_t tx_dest,
  input  noc_pkg::payload_t   tx_payload,
  output noc_pkg::flit_t      up_flit,
  output logic                up_valid,
  input  noc_pkg::flit_t      down_flit,
  input  logic                down_valid,
  input  noc_pkg::spine_idx_t down_spine,
  output logic                rx_valid,
  output noc_pkg::payload_t   rx_payload,
  output noc_pkg::spine_idx_t rx_src_spine,
  output noc_pkg::count_t     tx_count,
  output noc_pkg::count_t     rx_count
);
  import noc_pkg::*;

  // Strobes and counters
  always_ff @(posedge ACLK) begin
    if (rst) begin
      up_valid <= 1'b0;
      rx_valid <= 1'b0;
      tx_count <= '0;
      rx_count <= '0;
    end else begin
      up_valid <= tx_valid;
      rx_valid <= down_valid;
      if (tx_valid)   tx_count <= tx_count + count_t'(1);
      if (down_valid) rx_count <= rx_count + count_t'(1);
    end
  end

  // Pack the send side
  always_ff @(posedge ACLK) begin
    if (tx_valid) up_flit <= make_flit(tx_dest, tx_payload);
  end

  // Header is dropped, source spine kept
  always_ff @(posedge ACLK) begin
    if (down_valid) begin
      rx_payload   <= flit_payload(down_flit);
      rx_src_spine <= down_spine;
    end
  end

endmodule

/* src/leaf_node.sv */
`timescale 1ns/10ps
module leaf_node #(
  parameter noc_pkg::node_addr_t NODE_ADDR  = 6'b010011,
  parameter int                  FIFO_DEPTH = 4
) (
  input  logic                ACLK,
  input  logic                rst,
  // Local endpoint
  input  logic                tx_valid,
  input  noc_pkg::node_addr_t tx_dest,
  input  noc_pkg::payload_t   tx_payload,
  output logic                rx_valid,
  output noc_pkg::payload_t   rx_payload,
  output noc_pkg::spine_idx_t rx_src_spine,
  // Spine links
  output noc_pkg::flit_t      spine0_out_data,
  output logic                spine0_out_valid,
  input  noc_pkg::flit_t      spine0_in_data,
  input  logic                spine0_in_valid,
  input  noc_pkg::node_addr_t spine0_dest_addr,
  output noc_pkg::flit_t      spine1_out_data,
  output logic                spine1_out_valid,
  input  noc_pkg::flit_t      spine1_in_data,
  input  logic                spine1_in_valid,
  input  noc_pkg::node_addr_t spine1_dest_addr,
  output noc_pkg::flit_t      spine2_out_data,
  output logic                spine2_out_valid,
  input  noc_pkg::flit_t      spine2_in_data,
  input  logic                spine2_in_valid,
  input  noc_pkg::node_addr_t spine2_dest_addr,
  output noc_pkg::flit_t      spine3_out_data,
  output logic                spine3_out_valid,
  input  noc_pkg::flit_t      spine3_in_data,
  input  logic                spine3_in_valid,
  input  noc_pkg::node_addr_t spine3_dest_addr,
  // Statistics
  output noc_pkg::count_t     tx_count,
  output noc_pkg::count_t     rx_count,
  output noc_pkg::count_t     drop_count
);
  import noc_pkg::*;

  flit_t      up_flit;
  logic       up_valid;
  flit_t      down_flit;
  logic       down_valid;
  spine_idx_t down_spine;

  node_ni i_node_ni (
    .ACLK         (ACLK),
    .rst          (rst),
    .tx_valid     (tx_valid),
    .tx_dest      (tx_dest),
    .tx_payload   (tx_payload),
    .up_flit      (up_flit),
    .up_valid     (up_valid),
    .down_flit    (down_flit),
    .down_valid   (down_valid),
    .down_spine   (down_spine),
    .rx_valid     (rx_valid),
    .rx_payload   (rx_payload),
    .rx_src_spine (rx_src_spine),
    .tx_count     (tx_count),
    .rx_count     (rx_count)
  );

  leaf_router #(
    .NODE_ADDR  (NODE_ADDR),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_leaf_router (
    .ACLK             (ACLK),
    .rst              (rst),
    .spine0_in_data   (spine0_in_data),
    .spine0_in_valid  (spine0_in_valid),
    .spine0_dest_addr (spine0_dest_addr),
    .spine0_out_data  (spine0_out_data),
    .spine0_out_valid (spine0_out_valid),
    .spine1_in_data   (spine1_in_data),
    .spine1_in_valid  (spine1_in_valid),
    .spine1_dest_addr (spine1_dest_addr),
    .spine1_out_data  (spine1_out_data),
    .spine1_out_valid (spine1_out_valid),
    .spine2_in_data   (spine2_in_data),
    .spine2_in_valid  (spine2_in_valid),
    .spine2_dest_addr (spine2_dest_addr),
    .spine2_out_data  (spine2_out_data),
    .spine2_out_valid (spine2_out_valid),
    .spine3_in_data   (spine3_in_data),
    .spine3_in_valid  (spine3_in_valid),
    .spine3_dest_addr (spine3_dest_addr),
    .spine3_out_data  (spine3_out_data),
    .spine3_out_valid (spine3_out_valid),
    .up_flit          (up_flit),
    .up_valid         (up_valid),
    .down_flit        (down_flit),
    .down_valid       (down_valid),
    .down_spine       (down_spine),
    .drop_count       (drop_count)
  );

endmodule

/* verification/leaf_node_asserts.sv */
`timescale 1ns/10ps
module leaf_node_asserts (
  input logic            ACLK,
  input logic            rst,
  input logic            spine0_out_valid,
  input logic            spine1_out_valid,
  input logic            spine2_out_valid,
  input logic            spine3_out_valid,
  input logic            down_valid,
  input noc_pkg::count_t drop_count
);
  import noc_pkg::*;

  // A local flit goes to one spine only
  a_one_spine: assert property (@(posedge ACLK) disable iff (rst)
    $onehot0({spine3_out_valid, spine2_out_valid, spine1_out_valid, spine0_out_valid}))
    else $error("more than one spine_out_valid high");

  // At most four drops per cycle, modulo wrap
  a_drop_monotonic: assert property (@(posedge ACLK) disable iff (rst)
    !$past(rst) |-> count_t'(drop_count - $past(drop_count)) <= count_t'(4))
    else $error("drop_count moved backwards");

  a_reset_quiet: assert property (@(posedge ACLK) rst |=> !down_valid)
    else $error("down_valid high after a reset edge");

endmodule

bind leaf_router leaf_node_asserts i_leaf_node_asserts (.*);

/* verification/leaf_node_checker.sv */
`timescale 1ns/10ps
module leaf_node_checker #(
  parameter noc_pkg::node_addr_t NODE_ADDR  = 6'b010011,
  parameter int                  FIFO_DEPTH = 4
) (
  input  logic                                         ACLK,
  input  logic                                         rst,
  input  logic                                         tx_valid,
  input  noc_pkg::node_addr_t                          tx_dest,
  input  noc_pkg::payload_t                            tx_payload,
  input  logic                                         rx_valid,
  input  noc_pkg::payload_t                            rx_payload,
  input  noc_pkg::spine_idx_t                          rx_src_spine,
  input  noc_pkg::flit_t      [noc_pkg::NUM_SPINES-1:0] in_data,
  input  logic                [noc_pkg::NUM_SPINES-1:0] in_valid,
  input  noc_pkg::node_addr_t [noc_pkg::NUM_SPINES-1:0] in_dest,
  input  noc_pkg::flit_t      [noc_pkg::NUM_SPINES-1:0] out_data,
  input  logic                [noc_pkg::NUM_SPINES-1:0] out_valid,
  input  noc_pkg::count_t                              tx_count,
  input  noc_pkg::count_t                              rx_count,
  input  noc_pkg::count_t                              drop_count,
  output int                                           err_count,
  output int                                           pending
);
  import noc_pkg::*;

  flit_t    up_exp [NUM_SPINES][$];  // Expected uplink flits per spine
  int       up_due [NUM_SPINES][$];
  flit_t    fifo_q [NUM_SPINES][$];  // Model of each spine FIFO
  payload_t rx_pay [$];
  int       rx_spn [$];
  int       rx_due [$];
  int       cycle;
  int       rr;
  int       grant;
  count_t   tx_seen;
  count_t   rx_seen;
  count_t   exp_drop;

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
    err_count++;
  endtask

  task automatic failure(input string what);
    $display("Check failed at %0t: %s", $time, what);
    err_count++;
  endtask

  initial err_count = 0;

  // Sampled mid-cycle, away from both clock edge and stimulus change
  always @(negedge ACLK) begin
    if (rst) begin
      for (int s = 0; s < NUM_SPINES; s++) begin
        up_exp[s].delete();
        up_due[s].delete();
        fifo_q[s].delete();
      end
      rx_pay.delete();
      rx_spn.delete();
      rx_due.delete();
      cycle = 0;
      rr = 0;
      tx_seen = '0;
      rx_seen = '0;
      exp_drop = '0;
    end else begin
      cycle++;
      for (int s = 0; s < NUM_SPINES; s++) begin
        if (up_due[s].size() > 0 && up_due[s][0] == cycle) begin
          if (!out_valid[s]) failure($sformatf("spine%0d_out_valid missing", s));
          else if (out_data[s] !== up_exp[s][0])
            mismatch($sformatf("spine%0d_out_data", s), up_exp[s][0], out_data[s]);
          void'(up_exp[s].pop_front());
          void'(up_due[s].pop_front());
        end else if (out_valid[s]) begin
          mismatch($sformatf("spine%0d_out_valid", s), 0, 1);
        end
      end
      if (tx_count !== tx_seen) mismatch("tx_count", tx_seen, tx_count);
      if (tx_valid) begin
        up_exp[tx_dest[1:0]].push_back({tx_dest, tx_payload});
        up_due[tx_dest[1:0]].push_back(cycle + 2);
        tx_seen++;
      end
      // Delivered flits must come in predicted order and spine
      if (rx_valid) begin
        rx_seen++;
        if (rx_due.size() == 0 || rx_due[0] != cycle) begin
          failure("rx_valid high with no flit expected");
        end else begin
          if (rx_payload !== rx_pay[0]) mismatch("rx_payload", rx_pay[0], rx_payload);
          if (rx_src_spine !== spine_idx_t'(rx_spn[0]))
            mismatch("rx_src_spine", rx_spn[0], rx_src_spine);
        end
      end else if (rx_due.size() > 0 && rx_due[0] == cycle) begin
        failure("expected rx_valid did not come");
      end
      if (rx_due.size() > 0 && rx_due[0] == cycle) begin
        void'(rx_pay.pop_front());
        void'(rx_spn.pop_front());
        void'(rx_due.pop_front());
      end
      if (rx_count !== rx_seen) mismatch("rx_count", rx_seen, rx_count);
      if (drop_count !== exp_drop) mismatch("drop_count", exp_drop, drop_count);
      grant = -1;
      for (int i = 0; i < NUM_SPINES; i++) begin
        if (grant < 0 && fifo_q[(rr + i) % NUM_SPINES].size() > 0) grant = (rr + i) % NUM_SPINES;
      end
      for (int s = 0; s < NUM_SPINES; s++) begin
        if (in_valid[s]) begin
          if (in_dest[s] == NODE_ADDR && fifo_q[s].size() < FIFO_DEPTH)
            fifo_q[s].push_back(in_data[s]);
          else
            exp_drop++;  // Wrong address or FIFO full
        end
      end
      if (grant >= 0) begin
        rx_pay.push_back(payload_t'(fifo_q[grant].pop_front()));
        rx_spn.push_back(grant);
        rx_due.push_back(cycle + 2);
        rr = (grant + 1) % NUM_SPINES;
      end
    end
    pending = rx_due.size();
    for (int s = 0; s < NUM_SPINES; s++) pending += up_due[s].size() + fifo_q[s].size();
  end

endmodule

/* verification/tb_leaf_node.sv */
`timescale 1ns/10ps
module tb_leaf_node;
  import noc_pkg::*;

  localparam node_addr_t NODE_ADDR  = 6'b010011;
  localparam int         FIFO_DEPTH = 4;

  logic ACLK;
  logic rst;
  logic tx_valid;
  node_addr_t tx_dest;
  payload_t tx_payload;
  logic rx_valid;
  payload_t rx_payload;
  spine_idx_t rx_src_spine;
  flit_t      [NUM_SPINES-1:0] sp_in_data;
  logic       [NUM_SPINES-1:0] sp_in_valid;
  node_addr_t [NUM_SPINES-1:0] sp_dest;
  flit_t      [NUM_SPINES-1:0] sp_out_data;
  logic       [NUM_SPINES-1:0] sp_out_valid;
  count_t tx_count;
  count_t rx_count;
  count_t drop_count;
  int chk_errs;
  int pending;
  int local_errs;
  int errs_before;
  int tests_run;
  int tx_sent;
  int spine_sent;
  count_t drop_start;
  count_t rx_start;
  logic [31:0] lfsr_state;

  leaf_node #(.NODE_ADDR(NODE_ADDR), .FIFO_DEPTH(FIFO_DEPTH)) i_leaf_node (
    .ACLK(ACLK), .rst(rst),
    .tx_valid(tx_valid), .tx_dest(tx_dest), .tx_payload(tx_payload),
    .rx_valid(rx_valid), .rx_payload(rx_payload), .rx_src_spine(rx_src_spine),
    .spine0_out_data(sp_out_data[0]), .spine0_out_valid(sp_out_valid[0]),
    .spine0_in_data(sp_in_data[0]), .spine0_in_valid(sp_in_valid[0]),
    .spine0_dest_addr(sp_dest[0]),
    .spine1_out_data(sp_out_data[1]), .spine1_out_valid(sp_out_valid[1]),
    .spine1_in_data(sp_in_data[1]), .spine1_in_valid(sp_in_valid[1]),
    .spine1_dest_addr(sp_dest[1]),
    .spine2_out_data(sp_out_data[2]), .spine2_out_valid(sp_out_valid[2]),
    .spine2_in_data(sp_in_data[2]), .spine2_in_valid(sp_in_valid[2]),
    .spine2_dest_addr(sp_dest[2]),
    .spine3_out_data(sp_out_data[3]), .spine3_out_valid(sp_out_valid[3]),
    .spine3_in_data(sp_in_data[3]), .spine3_in_valid(sp_in_valid[3]),
    .spine3_dest_addr(sp_dest[3]),
    .tx_count(tx_count), .rx_count(rx_count), .drop_count(drop_count)
  );

  leaf_node_checker #(.NODE_ADDR(NODE_ADDR), .FIFO_DEPTH(FIFO_DEPTH)) i_checker (
    .ACLK(ACLK), .rst(rst), .tx_valid(tx_valid), .tx_dest(tx_dest), .tx_payload(tx_payload),
    .rx_valid(rx_valid), .rx_payload(rx_payload), .rx_src_spine(rx_src_spine),
    .in_data(sp_in_data), .in_valid(sp_in_valid), .in_dest(sp_dest),
    .out_data(sp_out_data), .out_valid(sp_out_valid), .tx_count(tx_count),
    .rx_count(rx_count), .drop_count(drop_count), .err_count(chk_errs), .pending(pending)
  );

  initial begin
    ACLK = 1'b0;
    forever #50 ACLK = ~ACLK;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic next_cycle();
    @(posedge ACLK);
    #5;
  endtask

  task automatic drive_idle();
    tx_valid = 1'b0;
    tx_dest = '0;
    tx_payload = '0;
    sp_in_data = '0;
    sp_in_valid = '0;
    sp_dest = '0;
  endtask

  task automatic send_local(input int prob_bits);
    tx_valid = (rand_bits(prob_bits) == 0);
    tx_dest = node_addr_t'(rand_bits(6));
    tx_payload = payload_t'(rand_bits(10));
    if (tx_valid) tx_sent++;
  endtask

  task automatic send_spine(input int s, input node_addr_t dest);
    sp_in_valid[s] = 1'b1;
    sp_in_data[s] = flit_t'(rand_bits(16));
    sp_dest[s] = dest;
    spine_sent++;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while ((pending != 0 || tx_valid || sp_in_valid != 0) && n < limit) begin
      drive_idle();
      next_cycle();
      n++;
    end
    if (pending != 0) begin
      $display("Timeout: flits still in flight after %0d cycles", limit);
      local_errs++;
    end
    repeat (3) next_cycle();  // Let the last checks run
  endtask

  task automatic end_test(input string name);
    int e;
    e = chk_errs + local_errs - errs_before;
    $display("Test %s: %s (%0d errors)", name, (e == 0) ? "ok" : "bad", e);
    errs_before = chk_errs + local_errs;
    tests_run++;
  endtask

  task automatic expect_count(input string name, input count_t exp, input count_t act);
    if (exp !== act) begin
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
      local_errs++;
    end
  endtask

  initial begin
    lfsr_state = 32'h12cd;
    local_errs = 0;
    errs_before = 0;
    tests_run = 0;
    tx_sent = 0;
    spine_sent = 0;
    rst = 1'b1;
    drive_idle();
    repeat (10) next_cycle();
    rst = 1'b0;
    next_cycle();

    repeat (60) begin  // Uplink steering
      send_local(1);
      next_cycle();
    end
    wait_drain(100);
    end_test("uplink_steering");

    repeat (80) begin  // Sparse downlink
      drive_idle();
      for (int s = 0; s < NUM_SPINES; s++) begin
        if (rand_bits(3) == 0) send_spine(s, NODE_ADDR);
      end
      next_cycle();
    end
    wait_drain(100);
    end_test("downlink_order");

    drop_start = drop_count;
    rx_start = rx_count;
    spine_sent = 0;
    repeat (40) begin  // Foreign addresses only
      drive_idle();
      for (int s = 0; s < NUM_SPINES; s++) begin
        if (rand_bits(2) == 0) send_spine(s, node_addr_t'(rand_bits(6)));
        if (sp_in_valid[s] && sp_dest[s] == NODE_ADDR) sp_dest[s] = NODE_ADDR ^ 6'b100000;
      end
      next_cycle();
    end
    wait_drain(100);
    expect_count("drop_count", count_t'(drop_start + spine_sent), drop_count);
    expect_count("rx_count", rx_start, rx_count);
    end_test("address_filter");

    drop_start = drop_count;
    repeat (FIFO_DEPTH) begin  // Simultaneous bursts on all spines
      drive_idle();
      for (int s = 0; s < NUM_SPINES; s++) send_spine(s, NODE_ADDR);
      next_cycle();
    end
    wait_drain(100);
    expect_count("drop_count", drop_start, drop_count);
    end_test("fairness");

    drop_start = drop_count;
    rx_start = rx_count;
    spine_sent = 0;
    repeat (200) begin  // Flood with some foreign traffic mixed in
      drive_idle();
      send_local(2);
      for (int s = 0; s < NUM_SPINES; s++)
        send_spine(s, (rand_bits(3) == 0) ? node_addr_t'(rand_bits(6)) : NODE_ADDR);
      next_cycle();
    end
    wait_drain(200);
    expect_count("delivered_plus_dropped", count_t'(spine_sent),
                 count_t'((rx_count - rx_start) + (drop_count - drop_start)));
    expect_count("tx_count", count_t'(tx_sent), tx_count);
    end_test("overflow");

    $display("Tests run %0d, errors %0d", tests_run, chk_errs + local_errs);
    if (chk_errs + local_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
src/noc_pkg.sv
src/spine_fifo.sv
src/downlink_arbiter.sv
src/uplink_steer.sv
src/leaf_router.sv
src/node_ni.sv
src/leaf_node.sv
verification/leaf_node_asserts.sv
verification/leaf_node_checker.sv
verification/tb_leaf_node.sv

/* run.sh */
#!/bin/sh
# Build and run the leaf node testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_leaf_node \
  -o sim_leaf_node > build.log 2>&1 &&
  ./obj_dir/sim_leaf_node > sim.log 2>&1
grep -qx "SIMULATION PASSED" sim.log && echo "PASS" && exit 0 || {
  echo "FAIL (see build.log and sim.log)"
  exit 1
}
